/* list.f */
+incdir+tb
source/backend_pkg.sv
source/fetch_pkg.sv
source/int_alu.sv
source/branch_unit.sv
source/alu_issue_reg.sv
source/alu_exec.sv
source/alu_pipe.sv
tb/alu_pipe_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0 -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = alu_pipe_tb
RTL_TOP    = alu_pipe
FILELIST   = list.f
LOG        = sim.log
FAIL_MSG   = Verification failed
PASS_MSG   = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not complete"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* tb/alu_ref.svh */
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// Expected integer result of one micro-op
function automatic backend_pkg::data_t expect_int(
    input backend_pkg::int_op_t    op,
    input logic                    immv,
    input logic                    uext,
    input backend_pkg::imm_t       imm,
    input backend_pkg::data_t      rs1,
    input backend_pkg::data_t      rs2,
    input fetch_pkg::vaddr_t       pc_base,
    input fetch_pkg::pred_offset_t slot
);
    backend_pkg::data_t b;
    backend_pkg::data_t upper;
    logic [4:0] sh;
    b = immv ? {{20{imm[11]}}, imm[11:0]} : rs2;
    upper = {imm, 12'h000};
    sh = b[4:0];
    case (op)
        backend_pkg::int_add:   return rs1 + b;
        backend_pkg::int_sub:   return rs1 - rs2;
        backend_pkg::int_lui:   return upper;
        backend_pkg::int_slt:   return uext ? 32'(rs1 < b) : 32'($signed(rs1) < $signed(b));
        backend_pkg::int_xor:   return rs1 ^ b;
        backend_pkg::int_and:   return rs1 & b;
        backend_pkg::int_sl:    return rs1 << sh;
        backend_pkg::int_srl:   return rs1 >> sh;
        backend_pkg::int_sra:   return $unsigned($signed(rs1) >>> sh);
        backend_pkg::int_auipc: return pc_base + 32'(slot) * 4 + upper;
        default:                return '0;
    endcase
endfunction

// Expected branch outcome, link value and misprediction flag
function automatic void expect_branch(
    input  backend_pkg::branch_op_t op,
    input  logic                    uext,
    input  backend_pkg::imm_t       imm,
    input  backend_pkg::data_t      rs1,
    input  backend_pkg::data_t      rs2,
    input  fetch_pkg::vaddr_t       pc_base,
    input  fetch_pkg::pred_offset_t slot,
    input  logic                    pred_taken,
    input  fetch_pkg::pred_offset_t pred_slot,
    input  fetch_pkg::vaddr_t       pred_target,
    output logic                    dir,
    output fetch_pkg::vaddr_t       tgt,
    output logic                    err,
    output backend_pkg::data_t      link
);
    backend_pkg::data_t offs;
    fetch_pkg::vaddr_t pc_tgt;
    logic lt;
    offs = {{19{imm[12]}}, imm[12:0]};
    pc_tgt = pc_base + 32'(slot) * 4 + offs;
    lt = uext ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));
    link = pc_base + (32'(slot) + 1) * 4;
    dir = 1'b0;
    tgt = pc_tgt;
    case (op)
        backend_pkg::branch_beq: dir = (rs1 == rs2);
        backend_pkg::branch_bne: dir = (rs1 != rs2);
        backend_pkg::branch_blt: dir = lt;
        backend_pkg::branch_bge: dir = !lt;
        default:                 dir = 1'b0;
    endcase
    if (op == backend_pkg::branch_jalr) begin
        tgt = rs1 + offs;
        err = (pred_target != tgt);
    end else if (op == backend_pkg::branch_jal) begin
        err = 1'b0;
    end else if (pred_slot == slot) begin
        err = (pred_taken != dir) || (pred_taken && pred_target != pc_tgt);
    end else begin
        // Predictor assumed not taken outside its slot
        err = dir;
    end
endfunction

`endif

/* tb/alu_pipe_tb.sv */
`timescale 1ns/1ps

module alu_pipe_tb;

    `include "alu_ref.svh"

    localparam int n_int = 300;
    localparam int n_corner = 150;
    localparam int n_branch = 200;
    localparam int n_jump = 60;
    localparam int n_flush = 200;
    // Each test end spends at most 11 cycles draining
    localparam int cycle_limit = 17 + n_int + n_corner + n_branch + n_jump + n_flush
                                 + 6 * 11 + 100;

    typedef struct packed {
        int                    test;
        int                    accept;
        logic                  intv;
        backend_pkg::rob_idx_t rob;
        backend_pkg::preg_t    rd;
        backend_pkg::data_t    data;
        logic                  dir;
        fetch_pkg::vaddr_t     target;
        logic                  err;
        logic [1:0]            br_type;
        logic [1:0]            ras_type;
    } exp_t;

    logic clk;
    logic reset;
    logic flush;
    logic issue_valid;
    backend_pkg::rob_idx_t issue_rob_idx;
    backend_pkg::preg_t issue_rd;
    logic issue_intv;
    backend_pkg::int_op_t issue_int_op;
    backend_pkg::branch_op_t issue_branch_op;
    logic issue_immv;
    logic issue_uext;
    backend_pkg::imm_t issue_imm;
    backend_pkg::data_t rs1_data;
    backend_pkg::data_t rs2_data;
    fetch_pkg::pred_offset_t issue_offset;
    fetch_pkg::br_type_t issue_br_type;
    fetch_pkg::ras_type_t issue_ras_type;
    fetch_pkg::vaddr_t stream_start_addr;
    logic stream_taken;
    fetch_pkg::pred_offset_t stream_size;
    fetch_pkg::vaddr_t stream_target;
    logic wb_valid;
    backend_pkg::rob_idx_t wb_rob_idx;
    backend_pkg::preg_t wb_rd;
    backend_pkg::data_t wb_data;
    logic br_valid;
    backend_pkg::rob_idx_t br_rob_idx;
    logic br_direction;
    fetch_pkg::vaddr_t br_target;
    logic br_error;
    fetch_pkg::br_type_t br_type;
    fetch_pkg::ras_type_t br_ras_type;

    exp_t exp_q[$];
    exp_t got;
    int cycle = 0;
    int errors = 0;
    int err_base = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int current_test = 0;
    string test_names [6] = '{"reset", "random_int", "compare_corners", "cond_branch",
                              "jumps", "flush"};
    backend_pkg::data_t corner_vals [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                            32'h8000_0000, 32'h7fff_ffff};

    alu_pipe i_alu_pipe (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_field(input int test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_names[test], field,
                     expected, actual);
            errors++;
        end
    endtask

    // Outputs are sampled before this edge updates them
    always @(posedge clk) begin
        if (wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Writeback of rob_idx %0d arrived with no micro-op outstanding",
                         wb_rob_idx);
                errors++;
            end else begin
                got = exp_q.pop_front();
                check_field(got.test, "latency", got.accept + 2, cycle);
                check_field(got.test, "wb_rob_idx", got.rob, wb_rob_idx);
                check_field(got.test, "wb_rd", got.rd, wb_rd);
                check_field(got.test, "wb_data", got.data, wb_data);
                check_field(got.test, "br_valid", !got.intv, br_valid);
                if (!got.intv) begin
                    check_field(got.test, "br_rob_idx", got.rob, br_rob_idx);
                    check_field(got.test, "br_direction", got.dir, br_direction);
                    check_field(got.test, "br_target", got.target, br_target);
                    check_field(got.test, "br_error", got.err, br_error);
                    check_field(got.test, "br_type", got.br_type, br_type);
                    check_field(got.test, "br_ras_type", got.ras_type, br_ras_type);
                end
            end
        end else if (br_valid === 1'b1) begin
            $display("Branch result of rob_idx %0d came without a writeback", br_rob_idx);
            errors++;
        end
    end

    task automatic check_idle();
        assert (wb_valid === 1'b0 && br_valid === 1'b0) else begin
            $display("A valid output was high during reset or in the first cycle after it");
            errors++;
        end
    endtask

    task automatic randomize_fields();
        issue_rob_idx = backend_pkg::rob_idx_t'($urandom);
        issue_rd = backend_pkg::preg_t'($urandom);
        issue_intv = 1'($urandom);
        issue_int_op = backend_pkg::int_op_t'($urandom_range(0, 11));
        issue_branch_op = backend_pkg::branch_op_t'($urandom_range(0, 5));
        issue_immv = 1'($urandom);
        issue_uext = 1'($urandom);
        issue_imm = backend_pkg::imm_t'($urandom);
        rs1_data = $urandom;
        rs2_data = $urandom;
        issue_offset = fetch_pkg::pred_offset_t'($urandom);
        issue_br_type = fetch_pkg::br_type_t'($urandom_range(0, 3));
        issue_ras_type = fetch_pkg::ras_type_t'($urandom_range(0, 3));
        stream_start_addr = $urandom;
        stream_taken = 1'($urandom);
        stream_size = fetch_pkg::pred_offset_t'($urandom);
        stream_target = $urandom;
    endtask

    // Make the predicted target match the resolved one
    task automatic aim_target();
        logic dir;
        logic err;
        fetch_pkg::vaddr_t tgt;
        backend_pkg::data_t link;
        expect_branch(issue_branch_op, issue_uext, issue_imm, rs1_data, rs2_data,
                      stream_start_addr, issue_offset, stream_taken, stream_size,
                      stream_target, dir, tgt, err, link);
        stream_target = tgt;
    endtask

    task automatic send(input logic valid, input logic do_flush);
        exp_t e;
        issue_valid = valid;
        flush = do_flush;
        if (do_flush) begin
            // Drops this cycle's issue and the one already in the issue register
            while (exp_q.size() != 0 && exp_q[$].accept >= cycle - 1) begin
                void'(exp_q.pop_back());
            end
        end else if (valid) begin
            e = '0;
            e.test = current_test;
            e.accept = cycle;
            e.intv = issue_intv;
            e.rob = issue_rob_idx;
            e.rd = issue_rd;
            e.br_type = issue_br_type;
            e.ras_type = issue_ras_type;
            if (issue_intv) begin
                e.data = expect_int(issue_int_op, issue_immv, issue_uext, issue_imm, rs1_data,
                                    rs2_data, stream_start_addr, issue_offset);
            end else begin
                expect_branch(issue_branch_op, issue_uext, issue_imm, rs1_data, rs2_data,
                              stream_start_addr, issue_offset, stream_taken, stream_size,
                              stream_target, e.dir, e.target, e.err, e.data);
            end
            exp_q.push_back(e);
        end
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        @(negedge clk);
        issue_valid = 1'b0;
        flush = 1'b0;
        while (exp_q.size() != 0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected results never came back", test_names[current_test],
                     exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (2) @(negedge clk);
        if (errors == err_base) begin
            tests_passed++;
            $display("%s: passed", test_names[current_test]);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_names[current_test], errors - err_base);
        end
        err_base = errors;
    endtask

    initial begin
        void'($urandom(94316));
        reset = 1'b1;
        flush = 1'b0;
        issue_valid = 1'b0;
        randomize_fields();
        repeat (16) begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b0;
        @(negedge clk);
        check_idle();
        finish_test();

        current_test = 1;
        for (int i = 0; i < n_int; i++) begin
            @(negedge clk);
            randomize_fields();
            issue_intv = 1'b1;
            send(1'b1, 1'b0);
        end
        finish_test();

        current_test = 2;
        for (int a = 0; a < 5; a++) begin
            for (int b = 0; b < 5; b++) begin
                for (int k = 0; k < 6; k++) begin
                    @(negedge clk);
                    randomize_fields();
                    rs1_data = corner_vals[a];
                    rs2_data = corner_vals[b];
                    issue_uext = k[0];
                    issue_immv = 1'b0;
                    issue_intv = (k < 2);
                    issue_int_op = backend_pkg::int_slt;
                    issue_branch_op = (k < 4) ? backend_pkg::branch_blt : backend_pkg::branch_bge;
                    send(1'b1, 1'b0);
                end
            end
        end
        finish_test();

        current_test = 3;
        for (int i = 0; i < n_branch; i++) begin
            @(negedge clk);
            randomize_fields();
            issue_intv = 1'b0;
            issue_branch_op = backend_pkg::branch_op_t'($urandom_range(0, 3));
            if ($urandom_range(0, 1) == 0) rs2_data = rs1_data;
            if ($urandom_range(0, 1) == 0) stream_size = issue_offset;
            if ($urandom_range(0, 2) == 0) aim_target();
            send(1'b1, 1'b0);
        end
        finish_test();

        current_test = 4;
        for (int i = 0; i < n_jump; i++) begin
            @(negedge clk);
            randomize_fields();
            issue_intv = 1'b0;
            issue_branch_op = i[0] ? backend_pkg::branch_jalr : backend_pkg::branch_jal;
            if ($urandom_range(0, 1) == 0) aim_target();
            send(1'b1, 1'b0);
        end
        finish_test();

        current_test = 5;
        for (int i = 0; i < n_flush; i++) begin
            @(negedge clk);
            randomize_fields();
            send($urandom_range(0, 3) != 0, $urandom_range(0, 7) == 0);
        end
        finish_test();

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* source/alu_pipe.sv */
`timescale 1ns/1ps

module alu_pipe (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       issue_valid,
    input  backend_pkg::rob_idx_t      issue_rob_idx,
    input  backend_pkg::preg_t         issue_rd,
    input  logic                       issue_intv,
    input  backend_pkg::int_op_t       issue_int_op,
    input  backend_pkg::branch_op_t    issue_branch_op,
    input  logic                       issue_immv,
    input  logic                       issue_uext,
    input  backend_pkg::imm_t          issue_imm,
    input  backend_pkg::data_t         rs1_data,
    input  backend_pkg::data_t         rs2_data,
    input  fetch_pkg::pred_offset_t    issue_offset,
    input  fetch_pkg::br_type_t        issue_br_type,
    input  fetch_pkg::ras_type_t       issue_ras_type,
    input  fetch_pkg::vaddr_t          stream_start_addr,
    input  logic                       stream_taken,
    input  fetch_pkg::pred_offset_t    stream_size,
    input  fetch_pkg::vaddr_t          stream_target,
    output logic                       wb_valid,
    output backend_pkg::rob_idx_t      wb_rob_idx,
    output backend_pkg::preg_t         wb_rd,
    output backend_pkg::data_t         wb_data,
    output logic                       br_valid,
    output backend_pkg::rob_idx_t      br_rob_idx,
    output logic                       br_direction,
    output fetch_pkg::vaddr_t          br_target,
    output logic                       br_error,
    output fetch_pkg::br_type_t        br_type,
    output fetch_pkg::ras_type_t       br_ras_type
);
    // Issue stage to execute stage
    logic                    s1_valid;
    backend_pkg::rob_idx_t   s1_rob_idx;
    backend_pkg::preg_t      s1_rd;
    logic                    s1_intv;
    backend_pkg::int_op_t    s1_int_op;
    backend_pkg::branch_op_t s1_branch_op;
    logic                    s1_immv;
    logic                    s1_uext;
    backend_pkg::imm_t       s1_imm;
    backend_pkg::data_t      s1_rs1_data;
    backend_pkg::data_t      s1_rs2_data;
    fetch_pkg::pred_offset_t s1_offset;
    fetch_pkg::br_type_t     s1_br_type;
    fetch_pkg::ras_type_t    s1_ras_type;
    fetch_pkg::vaddr_t       s1_start_addr;
    logic                    s1_stream_taken;
    fetch_pkg::pred_offset_t s1_stream_size;
    fetch_pkg::vaddr_t       s1_stream_target;

    alu_issue_reg i_alu_issue_reg (.*);

    alu_exec i_alu_exec (.*);

endmodule

/* source/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       s1_valid,
    input  backend_pkg::rob_idx_t      s1_rob_idx,
    input  backend_pkg::preg_t         s1_rd,
    input  logic                       s1_intv,
    input  backend_pkg::int_op_t       s1_int_op,
    input  backend_pkg::branch_op_t    s1_branch_op,
    input  logic                       s1_immv,
    input  logic                       s1_uext,
    input  backend_pkg::imm_t          s1_imm,
    input  backend_pkg::data_t         s1_rs1_data,
    input  backend_pkg::data_t         s1_rs2_data,
    input  fetch_pkg::pred_offset_t    s1_offset,
    input  fetch_pkg::br_type_t        s1_br_type,
    input  fetch_pkg::ras_type_t       s1_ras_type,
    input  fetch_pkg::vaddr_t          s1_start_addr,
    input  logic                       s1_stream_taken,
    input  fetch_pkg::pred_offset_t    s1_stream_size,
    input  fetch_pkg::vaddr_t          s1_stream_target,
    output logic                       wb_valid,
    output backend_pkg::rob_idx_t      wb_rob_idx,
    output backend_pkg::preg_t         wb_rd,
    output backend_pkg::data_t         wb_data,
    output logic                       br_valid,
    output backend_pkg::rob_idx_t      br_rob_idx,
    output logic                       br_direction,
    output fetch_pkg::vaddr_t          br_target,
    output logic                       br_error,
    output fetch_pkg::br_type_t        br_type,
    output fetch_pkg::ras_type_t       br_ras_type
);
    backend_pkg::data_t int_result;
    backend_pkg::data_t link;
    logic direction;
    fetch_pkg::vaddr_t target;
    logic error;

    int_alu i_int_alu (
        .immv       (s1_immv),
        .uext       (s1_uext),
        .imm        (s1_imm),
        .rs1_data   (s1_rs1_data),
        .rs2_data   (s1_rs2_data),
        .op         (s1_int_op),
        .start_addr (s1_start_addr),
        .offset     (s1_offset),
        .result     (int_result)
    );

    branch_unit i_branch_unit (
        .uext          (s1_uext),
        .imm           (s1_imm),
        .rs1_data      (s1_rs1_data),
        .rs2_data      (s1_rs2_data),
        .op            (s1_branch_op),
        .start_addr    (s1_start_addr),
        .offset        (s1_offset),
        .stream_taken  (s1_stream_taken),
        .stream_size   (s1_stream_size),
        .stream_target (s1_stream_target),
        .direction     (direction),
        .target        (target),
        .error         (error),
        .link          (link)
    );

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
        end else begin
            wb_valid <= s1_valid;
            br_valid <= s1_valid && !s1_intv;
        end
    end

    // Result fields hold their last value between micro-ops
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_rob_idx   <= '0;
            wb_rd        <= '0;
            wb_data      <= '0;
            br_rob_idx   <= '0;
            br_direction <= 1'b0;
            br_target    <= '0;
            br_error     <= 1'b0;
            br_type      <= fetch_pkg::br_direct;
            br_ras_type  <= fetch_pkg::ras_none;
        end else if (s1_valid) begin
            wb_rob_idx   <= s1_rob_idx;
            wb_rd        <= s1_rd;
            wb_data      <= s1_intv ? int_result : link;
            br_rob_idx   <= s1_rob_idx;
            br_direction <= direction;
            br_target    <= target;
            br_error     <= error;
            br_type      <= s1_br_type;
            br_ras_type  <= s1_ras_type;
        end
    end

endmodule

/* source/alu_issue_reg.sv */
`timescale 1ns/1ps

module alu_issue_reg (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       issue_valid,
    input  backend_pkg::rob_idx_t      issue_rob_idx,
    input  backend_pkg::preg_t         issue_rd,
    input  logic                       issue_intv,
    input  backend_pkg::int_op_t       issue_int_op,
    input  backend_pkg::branch_op_t    issue_branch_op,
    input  logic                       issue_immv,
    input  logic                       issue_uext,
    input  backend_pkg::imm_t          issue_imm,
    input  backend_pkg::data_t         rs1_data,
    input  backend_pkg::data_t         rs2_data,
    input  fetch_pkg::pred_offset_t    issue_offset,
    input  fetch_pkg::br_type_t        issue_br_type,
    input  fetch_pkg::ras_type_t       issue_ras_type,
    input  fetch_pkg::vaddr_t          stream_start_addr,
    input  logic                       stream_taken,
    input  fetch_pkg::pred_offset_t    stream_size,
    input  fetch_pkg::vaddr_t          stream_target,
    output logic                       s1_valid,
    output backend_pkg::rob_idx_t      s1_rob_idx,
    output backend_pkg::preg_t         s1_rd,
    output logic                       s1_intv,
    output backend_pkg::int_op_t       s1_int_op,
    output backend_pkg::branch_op_t    s1_branch_op,
    output logic                       s1_immv,
    output logic                       s1_uext,
    output backend_pkg::imm_t          s1_imm,
    output backend_pkg::data_t         s1_rs1_data,
    output backend_pkg::data_t         s1_rs2_data,
    output fetch_pkg::pred_offset_t    s1_offset,
    output fetch_pkg::br_type_t        s1_br_type,
    output fetch_pkg::ras_type_t       s1_ras_type,
    output fetch_pkg::vaddr_t          s1_start_addr,
    output logic                       s1_stream_taken,
    output fetch_pkg::pred_offset_t    s1_stream_size,
    output fetch_pkg::vaddr_t          s1_stream_target
);

    // A flush also drops the micro-op issued in the same cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            s1_rob_idx       <= issue_rob_idx;
            s1_rd            <= issue_rd;
            s1_intv          <= issue_intv;
            s1_int_op        <= issue_int_op;
            s1_branch_op     <= issue_branch_op;
            s1_immv          <= issue_immv;
            s1_uext          <= issue_uext;
            s1_imm           <= issue_imm;
            s1_rs1_data      <= rs1_data;
            s1_rs2_data      <= rs2_data;
            s1_offset        <= issue_offset;
            s1_br_type       <= issue_br_type;
            s1_ras_type      <= issue_ras_type;
            s1_start_addr    <= stream_start_addr;
            s1_stream_taken  <= stream_taken;
            s1_stream_size   <= stream_size;
            s1_stream_target <= stream_target;
        end
    end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  logic                     uext,
    input  backend_pkg::imm_t        imm,
    input  backend_pkg::data_t       rs1_data,
    input  backend_pkg::data_t       rs2_data,
    input  backend_pkg::branch_op_t  op,
    input  fetch_pkg::vaddr_t        start_addr,
    input  fetch_pkg::pred_offset_t  offset,
    input  logic                     stream_taken,
    input  fetch_pkg::pred_offset_t  stream_size,
    input  fetch_pkg::vaddr_t        stream_target,
    output logic                     direction,
    output fetch_pkg::vaddr_t        target,
    output logic                     error,
    output backend_pkg::data_t       link
);
    backend_pkg::data_t s_imm;
    fetch_pkg::vaddr_t jalr_target;
    fetch_pkg::vaddr_t br_target;
    logic [fetch_pkg::pred_width:0] next_slot;
    logic equal;
    logic ult;
    logic slt;
    logic lt;
    logic stream_hit;
    logic branch_error;

    assign equal = rs1_data == rs2_data;
    assign ult = rs1_data < rs2_data;
    assign slt = (rs1_data[backend_pkg::xlen-1] != rs2_data[backend_pkg::xlen-1]) ?
                 rs1_data[backend_pkg::xlen-1] : ult;
    assign lt = uext ? ult : slt;

    always_comb begin
        case (op)
            backend_pkg::branch_beq: direction = equal;
            backend_pkg::branch_bne: direction = ~equal;
            backend_pkg::branch_blt: direction = lt;
            backend_pkg::branch_bge: direction = ~lt;
            default:                 direction = 1'b0;
        endcase
    end

    // Sign extended 13-bit B-type immediate
    assign s_imm = {{(backend_pkg::xlen-13){imm[12]}}, imm[12:0]};
    assign jalr_target = rs1_data + s_imm;
    assign br_target = start_addr + {offset, 2'b00} + s_imm;
    assign target = (op == backend_pkg::branch_jalr) ? jalr_target : br_target;

    // Return address is the following slot of the stream
    assign next_slot = {1'b0, offset} + 1'b1;
    assign link = start_addr + {next_slot, 2'b00};

    // Outside the predicted slot the predictor assumed not taken
    assign stream_hit = stream_size == offset;
    assign branch_error = stream_hit ?
                          (stream_taken ^ direction) |
                          (stream_taken & (stream_target != br_target)) :
                          direction;

    always_comb begin
        case (op)
            backend_pkg::branch_jalr: error = stream_target != jalr_target;
            backend_pkg::branch_jal:  error = 1'b0;
            default:                  error = branch_error;
        endcase
    end

endmodule

/* source/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
    input  logic                    immv,
    input  logic                    uext,
    input  backend_pkg::imm_t       imm,
    input  backend_pkg::data_t      rs1_data,
    input  backend_pkg::data_t      rs2_data,
    input  backend_pkg::int_op_t    op,
    input  fetch_pkg::vaddr_t       start_addr,
    input  fetch_pkg::pred_offset_t offset,
    output backend_pkg::data_t      result
);
    backend_pkg::data_t s_imm;
    backend_pkg::data_t lui_imm;
    backend_pkg::data_t op2;
    backend_pkg::data_t pc_offset;
    logic [backend_pkg::shamt_width-1:0] shamt;
    logic ult;
    logic slt;

    assign s_imm = {{(backend_pkg::xlen-12){imm[11]}}, imm[11:0]};
    assign lui_imm = {imm[19:0], 12'b0};
    assign op2 = immv ? s_imm : rs2_data;
    assign shamt = op2[backend_pkg::shamt_width-1:0];

    // Byte offset of the instruction within its fetch stream
    assign pc_offset = {{(backend_pkg::xlen-fetch_pkg::pred_width-2){1'b0}}, offset, 2'b00};

    assign ult = rs1_data < op2;

    // When the signs differ the negative operand is smaller
    assign slt = (rs1_data[backend_pkg::xlen-1] != op2[backend_pkg::xlen-1]) ?
                 rs1_data[backend_pkg::xlen-1] : ult;

    always_comb begin
        case (op)
            backend_pkg::int_add: begin
                result = rs1_data + op2;
            end
            backend_pkg::int_sub: begin
                result = rs1_data - rs2_data;
            end
            backend_pkg::int_lui: begin
                result = lui_imm;
            end
            backend_pkg::int_slt: begin
                result = {{(backend_pkg::xlen-1){1'b0}}, uext ? ult : slt};
            end
            backend_pkg::int_xor: begin
                result = rs1_data ^ op2;
            end
            backend_pkg::int_and: begin
                result = rs1_data & op2;
            end
            backend_pkg::int_sl: begin
                result = rs1_data << shamt;
            end
            backend_pkg::int_srl: begin
                result = rs1_data >> shamt;
            end
            backend_pkg::int_sra: begin
                result = $signed(rs1_data) >>> shamt;
            end
            backend_pkg::int_auipc: begin
                result = start_addr + pc_offset + lui_imm;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

    localparam int vaddr_size = 32;
    localparam int pred_width = 3;

    typedef logic [vaddr_size-1:0] vaddr_t;

    // Slot of an instruction inside a fetch stream of up to 8
    typedef logic [pred_width-1:0] pred_offset_t;

    // Predictor's branch class
    typedef enum logic [1:0] {
        br_direct,
        br_jump,
        br_call,
        br_ind
    } br_type_t;

    typedef enum logic [1:0] {
        ras_none,
        ras_push,
        ras_pop,
        ras_poppush
    } ras_type_t;

endpackage

/* source/backend_pkg.sv */
package backend_pkg;

    localparam int xlen = 32;
    localparam int shamt_width = $clog2(xlen);
    localparam int imm_width = 20;
    localparam int rob_idx_width = 5;
    localparam int preg_width = 6;
    localparam int int_op_width = 4;
    localparam int branch_op_width = 3;

    typedef logic [xlen-1:0] data_t;

    // Decoded immediate with I-type in 11:0, B-type in 12:0 and U-type in 19:0
    typedef logic [imm_width-1:0] imm_t;

    typedef logic [rob_idx_width-1:0] rob_idx_t;
    typedef logic [preg_width-1:0] preg_t;

    typedef enum logic [int_op_width-1:0] {
        int_add,
        int_sub,
        int_lui,
        int_slt,
        int_xor,
        int_and,
        int_sl,
        int_srl,
        int_sra,
        int_auipc
    } int_op_t;

    typedef enum logic [branch_op_width-1:0] {
        branch_beq,
        branch_bne,
        branch_blt,
        branch_bge,
        branch_jal,
        branch_jalr
    } branch_op_t;

endpackage
